/* src/spiRegPkg.sv */
// Register map of the SPI controller. All accesses are full 32-bit words,
// and the byte address is decoded on word boundaries only

package spiRegPkg;

    ///////////////////////////////////////////////////////////////////////
    // Field widths and reset values
    ///////////////////////////////////////////////////////////////////////

    localparam int SCKDIV_W = 12;
    localparam int CS_W     = 4;
    localparam int MARK_W   = 3;

    localparam logic [SCKDIV_W-1:0] SCKDIV_RST = SCKDIV_W'(3);
    localparam logic [CS_W-1:0]     CSDEF_RST  = '1;

    ///////////////////////////////////////////////////////////////////////
    // Word addresses
    ///////////////////////////////////////////////////////////////////////

    typedef enum logic [7:0] {
        SCKDIV  = 8'h00,
        SCKMODE = 8'h04,
        CSID    = 8'h10,
        CSDEF   = 8'h14,
        CSMODE  = 8'h18,
        TXDATA  = 8'h48,
        RXDATA  = 8'h4C,
        TXMARK  = 8'h50,
        RXMARK  = 8'h54,
        IE      = 8'h70,
        IP      = 8'h74
    } regAddrE;

    // Hold chip-select mode behaves exactly like auto
    typedef enum logic [1:0] {
        AUTO = 2'd0,
        HOLD = 2'd2,
        OFF  = 2'd3
    } csModeE;

endpackage

/* src/spiXferPkg.sv */
// Transfer-side types shared by the register block, FIFOs and engine.
// Frames are fixed at 8 bits, MSB first

package spiXferPkg;

    localparam int FRAME_W = 8;
    // Depth is 2**FIFO_AW entries
    localparam int FIFO_AW = 3;

    // Frame sequence with one state change per divider tick
    typedef enum logic [2:0] {
        IDLE,
        LEAD,
        ACTIVE0,
        ACTIVE1,
        TRAIL
    } xferStateE;

    // Live configuration driven out of the register block
    typedef struct packed {
        logic [spiRegPkg::SCKDIV_W-1:0]        sckDiv;
        logic [1:0]                            sckMode;  // bit 1 polarity, bit 0 phase
        logic [$clog2(spiRegPkg::CS_W)-1:0]    csId;
        logic [spiRegPkg::CS_W-1:0]            csDef;
        spiRegPkg::csModeE                     csMode;
    } spiCfgS;

    // Occupancy report of one FIFO
    typedef struct packed {
        logic             full;
        logic             empty;
        logic [FIFO_AW:0] count;  // 0 to depth
    } fifoStatS;

endpackage

/* src/spiApbRegs.sv */
// APB slave with no wait states. A TXDATA write while the TX FIFO is full is dropped,
// and an RXDATA read pops only if the returned word showed data present

`timescale 1ns/1ps

module spiApbRegs (
    input  logic                        PCLK,
    input  logic                        PRESETn,
    input  logic                        PSEL,
    input  logic                        PENABLE,
    input  logic                        PWRITE,
    input  logic [7:0]                  PADDR,
    input  logic [31:0]                 PWDATA,
    input  spiXferPkg::fifoStatS        txStat,
    input  spiXferPkg::fifoStatS        rxStat,
    input  logic [spiXferPkg::FRAME_W-1:0] rxHead,
    output logic [31:0]                 PRDATA,
    output spiXferPkg::spiCfgS          cfg,
    output logic                        txPush,
    output logic [spiXferPkg::FRAME_W-1:0] txPushData,
    output logic                        rxPop,
    output logic                        SPIIntr
);
    import spiRegPkg::*;

    regAddrE             regAddr;
    logic                wrAccess;
    logic                rdAccess;
    logic [MARK_W-1:0]   txMark;
    logic [MARK_W-1:0]   rxMark;
    logic [1:0]          intrEn;
    logic                txPend;
    logic                rxPend;

    assign regAddr  = regAddrE'({PADDR[7:2], 2'b00});
    assign wrAccess = PSEL & PENABLE & PWRITE;
    assign rdAccess = PSEL & PENABLE & ~PWRITE;

    // PRDATA[8] holds the empty flag captured for this read
    assign txPush     = wrAccess & (regAddr == TXDATA) & ~txStat.full;
    assign txPushData = PWDATA[7:0];
    assign rxPop      = rdAccess & (regAddr == RXDATA) & ~PRDATA[8];

    ///////////////////////////////////////////////////////////////////////
    // Control registers and watermark pending bits
    ///////////////////////////////////////////////////////////////////////

    always_ff @(posedge PCLK or negedge PRESETn) begin
        if (!PRESETn) begin
            cfg.sckDiv  <= SCKDIV_RST;
            cfg.sckMode <= '0;
            cfg.csId    <= '0;
            cfg.csDef   <= CSDEF_RST;
            cfg.csMode  <= AUTO;
            txMark      <= '0;
            rxMark      <= '0;
            intrEn      <= '0;
            txPend      <= 1'b0;
            rxPend      <= 1'b0;
        end else begin
            if (wrAccess) begin
                case (regAddr)
                    SCKDIV:  cfg.sckDiv  <= PWDATA[SCKDIV_W-1:0];
                    SCKMODE: cfg.sckMode <= PWDATA[1:0];
                    CSID:    cfg.csId    <= PWDATA[$bits(cfg.csId)-1:0];
                    CSDEF:   cfg.csDef   <= PWDATA[CS_W-1:0];
                    CSMODE:  cfg.csMode  <= csModeE'(PWDATA[1:0]);
                    TXMARK:  txMark      <= PWDATA[MARK_W-1:0];
                    RXMARK:  rxMark      <= PWDATA[MARK_W-1:0];
                    IE:      intrEn      <= PWDATA[1:0];
                    default: ;
                endcase
            end
            // Pending follows the counts one cycle behind
            txPend <= txStat.count < {1'b0, txMark};
            rxPend <= rxStat.count > {1'b0, rxMark};
        end
    end

    // Read mux reloaded every cycle from the current address
    always_ff @(posedge PCLK or negedge PRESETn) begin
        if (!PRESETn) begin
            PRDATA <= '0;
        end else begin
            case (regAddr)
                SCKDIV:  PRDATA <= 32'(cfg.sckDiv);
                SCKMODE: PRDATA <= 32'(cfg.sckMode);
                CSID:    PRDATA <= 32'(cfg.csId);
                CSDEF:   PRDATA <= 32'(cfg.csDef);
                CSMODE:  PRDATA <= 32'(cfg.csMode);
                TXDATA:  PRDATA <= 32'({txStat.full, 8'h00});
                RXDATA:  PRDATA <= 32'({rxStat.empty, rxHead});
                TXMARK:  PRDATA <= 32'(txMark);
                RXMARK:  PRDATA <= 32'(rxMark);
                IE:      PRDATA <= 32'(intrEn);
                IP:      PRDATA <= 32'({rxPend, txPend});
                default: PRDATA <= '0;
            endcase
        end
    end

    assign SPIIntr = |({rxPend, txPend} & intrEn);

endmodule

/* src/spiFifo.sv */
// Single-clock FIFO. Push when full and pop when empty are ignored;
// the head entry is visible without a pop

`timescale 1ns/1ps

module spiFifo (
    input  logic                           PCLK,
    input  logic                           PRESETn,
    input  logic                           push,
    input  logic                           pop,
    input  logic [spiXferPkg::FRAME_W-1:0] pushData,
    output logic [spiXferPkg::FRAME_W-1:0] popData,
    output spiXferPkg::fifoStatS           stat
);
    import spiXferPkg::*;

    logic [FRAME_W-1:0] mem [2**FIFO_AW];
    // Extra top bit tells full from empty when the addresses match
    logic [FIFO_AW:0]   wrPtr;
    logic [FIFO_AW:0]   rdPtr;
    logic               doPush;
    logic               doPop;

    assign doPush = push & ~stat.full;
    assign doPop  = pop & ~stat.empty;

    always_ff @(posedge PCLK) begin
        if (doPush) begin
            mem[wrPtr[FIFO_AW-1:0]] <= pushData;
        end
    end

    always_ff @(posedge PCLK or negedge PRESETn) begin
        if (!PRESETn) begin
            wrPtr <= '0;
            rdPtr <= '0;
        end else begin
            if (doPush) wrPtr <= wrPtr + 1'b1;
            if (doPop)  rdPtr <= rdPtr + 1'b1;
        end
    end

    assign popData    = mem[rdPtr[FIFO_AW-1:0]];
    assign stat.count = wrPtr - rdPtr;
    assign stat.empty = (wrPtr == rdPtr);
    assign stat.full  = (wrPtr == {~rdPtr[FIFO_AW], rdPtr[FIFO_AW-1:0]});

endmodule

/* src/spiClockGen.sv */
// Serial clock divider. One Sck half-period is sckDiv+1 PCLK cycles;
// a lowered sckDiv takes effect at once

`timescale 1ns/1ps

module spiClockGen (
    input  logic               PCLK,
    input  logic               PRESETn,
    input  spiXferPkg::spiCfgS cfg,
    output logic               sckTick
);
    import spiRegPkg::*;

    logic [SCKDIV_W-1:0] divCnt;

    // Terminal count that also catches a divider just lowered
    assign sckTick = (divCnt >= cfg.sckDiv);

    always_ff @(posedge PCLK or negedge PRESETn) begin
        if (!PRESETn) begin
            divCnt <= '0;
        end else if (sckTick) begin
            divCnt <= '0;
        end else begin
            divCnt <= divCnt + 1'b1;
        end
    end

endmodule

/* src/spiXferEngine.sv */
// Each byte is framed by one lead tick, eight bit periods and one trail tick.
// A received byte is dropped when the RX FIFO is full; nothing stalls

`timescale 1ns/1ps

module spiXferEngine (
    input  logic                           PCLK,
    input  logic                           PRESETn,
    input  logic                           sckTick,
    input  spiXferPkg::spiCfgS             cfg,
    input  spiXferPkg::fifoStatS           txStat,
    input  logic [spiXferPkg::FRAME_W-1:0] txHead,
    input  logic                           SPIIn,
    output logic                           txPop,
    output logic                           rxPush,
    output logic [spiXferPkg::FRAME_W-1:0] rxData,
    output logic                           SPIOut,
    output logic                           Sck,
    output logic [spiRegPkg::CS_W-1:0]     SPICS
);
    import spiRegPkg::*;
    import spiXferPkg::*;

    localparam int BIT_W = $clog2(FRAME_W);

    xferStateE          state;
    logic [BIT_W-1:0]   bitCnt;
    logic [FRAME_W-1:0] txShift;
    logic [FRAME_W-1:0] rxShift;
    logic               pha;
    logic               lastBit;
    logic               shiftEn;
    logic               sampleEn;

    assign pha     = cfg.sckMode[0];
    assign lastBit = (bitCnt == BIT_W'(FRAME_W - 1));
    assign txPop   = sckTick & (state == IDLE) & ~txStat.empty;

    // Phase 1 holds the MSB through the first bit period
    assign shiftEn  = sckTick & (pha ? (state == ACTIVE0) & (bitCnt != '0)
                                     : (state == ACTIVE1) & ~lastBit);
    assign sampleEn = sckTick & (pha ? (state == ACTIVE1) : (state == ACTIVE0));

    ///////////////////////////////////////////////////////////////////////
    // Frame sequencing
    ///////////////////////////////////////////////////////////////////////

    always_ff @(posedge PCLK or negedge PRESETn) begin
        if (!PRESETn) begin
            state  <= IDLE;
            bitCnt <= '0;
            rxPush <= 1'b0;
        end else begin
            // Fires in the first TRAIL cycle, after the last sample landed
            rxPush <= sckTick & (state == ACTIVE1) & lastBit;
            if (sckTick) begin
                case (state)
                    IDLE: if (!txStat.empty) state <= LEAD;
                    LEAD: begin
                        state  <= ACTIVE0;
                        bitCnt <= '0;
                    end
                    ACTIVE0: state <= ACTIVE1;
                    ACTIVE1: begin
                        if (lastBit) begin
                            state <= TRAIL;
                        end else begin
                            state  <= ACTIVE0;
                            bitCnt <= bitCnt + 1'b1;
                        end
                    end
                    TRAIL:   state <= IDLE;
                    default: state <= IDLE;
                endcase
            end
        end
    end

    always_ff @(posedge PCLK or negedge PRESETn) begin
        if (!PRESETn) begin
            txShift <= '0;
        end else if (txPop) begin
            txShift <= txHead;
        end else if (shiftEn) begin
            txShift <= {txShift[FRAME_W-2:0], 1'b0};
        end
    end

    always_ff @(posedge PCLK) begin
        if (sampleEn) begin
            rxShift <= {rxShift[FRAME_W-2:0], SPIIn};
        end
    end

    assign rxData = rxShift;
    assign SPIOut = txShift[FRAME_W-1];
    assign Sck    = cfg.sckMode[1] ^ (state == ACTIVE1);

    // Selected pin flips away from its default for the whole frame
    always_comb begin
        SPICS = cfg.csDef;
        if ((state != IDLE) && (cfg.csMode != OFF)) begin
            SPICS[cfg.csId] = ~cfg.csDef[cfg.csId];
        end
    end

endmodule

/* src/spiApb.sv */
// SPI controller on APB. PREADY is always high; accesses are 32-bit words.
// Loopback, if wanted, is wired outside between SPIOut and SPIIn

`timescale 1ns/1ps

module spiApb (
    input  logic                       PCLK,
    input  logic                       PRESETn,
    input  logic                       PSEL,
    input  logic                       PENABLE,
    input  logic                       PWRITE,
    input  logic [7:0]                 PADDR,
    input  logic [31:0]                PWDATA,
    output logic [31:0]                PRDATA,
    output logic                       PREADY,
    output logic                       SPIOut,
    input  logic                       SPIIn,
    output logic                       Sck,
    output logic [spiRegPkg::CS_W-1:0] SPICS,
    output logic                       SPIIntr
);
    import spiXferPkg::*;

    spiCfgS             cfg;
    fifoStatS           txStat;
    fifoStatS           rxStat;
    logic               txPush;
    logic               txPop;
    logic               rxPush;
    logic               rxPop;
    logic [FRAME_W-1:0] txPushData;
    logic [FRAME_W-1:0] txHead;
    logic [FRAME_W-1:0] rxData;
    logic [FRAME_W-1:0] rxHead;
    logic               sckTick;

    assign PREADY = 1'b1;

    spiApbRegs u_regs (
        .PCLK(PCLK), .PRESETn(PRESETn), .PSEL(PSEL), .PENABLE(PENABLE),
        .PWRITE(PWRITE), .PADDR(PADDR), .PWDATA(PWDATA),
        .txStat(txStat), .rxStat(rxStat), .rxHead(rxHead),
        .PRDATA(PRDATA), .cfg(cfg), .txPush(txPush), .txPushData(txPushData),
        .rxPop(rxPop), .SPIIntr(SPIIntr)
    );

    spiFifo txFifo (
        .PCLK(PCLK), .PRESETn(PRESETn), .push(txPush), .pop(txPop),
        .pushData(txPushData), .popData(txHead), .stat(txStat)
    );

    spiFifo rxFifo (
        .PCLK(PCLK), .PRESETn(PRESETn), .push(rxPush), .pop(rxPop),
        .pushData(rxData), .popData(rxHead), .stat(rxStat)
    );

    spiClockGen u_clkGen (
        .PCLK(PCLK), .PRESETn(PRESETn), .cfg(cfg), .sckTick(sckTick)
    );

    spiXferEngine u_engine (
        .PCLK(PCLK), .PRESETn(PRESETn), .sckTick(sckTick), .cfg(cfg),
        .txStat(txStat), .txHead(txHead), .SPIIn(SPIIn),
        .txPop(txPop), .rxPush(rxPush), .rxData(rxData),
        .SPIOut(SPIOut), .Sck(Sck), .SPICS(SPICS)
    );

endmodule

/* verif/spiApbTb.sv */
// SPIOut is looped back to SPIIn. The interrupt model reads FIFO pops and pushes
// from chip-select edges, so it is only valid with sckDiv 0 and auto chip select

`timescale 1ns/1ps

module spiApbTb;
    import spiRegPkg::*;

    logic        PCLK;
    logic        PRESETn;
    logic        PSEL;
    logic        PENABLE;
    logic        PWRITE;
    logic [7:0]  PADDR;
    logic [31:0] PWDATA;
    logic [31:0] PRDATA;
    logic        PREADY;
    logic        SPIOut;
    logic        SPIIn;
    logic        Sck;
    logic [3:0]  SPICS;
    logic        SPIIntr;

    // Shadow of the configuration last written
    logic [3:0]  csDefCur;
    logic [1:0]  csIdCur;
    logic [1:0]  csModeCur;
    logic        polCur;
    logic        monOn;
    // Occupancy model for the interrupt check
    logic        intrOn;
    logic        modelReady;
    logic [3:0]  txCnt;
    logic [3:0]  rxCnt;
    logic        txPushEv;
    logic        rxPopEv;
    logic        prevAct;
    logic        expIntr;
    integer      seed;

    spiApb u_dut (
        .PCLK(PCLK), .PRESETn(PRESETn), .PSEL(PSEL), .PENABLE(PENABLE),
        .PWRITE(PWRITE), .PADDR(PADDR), .PWDATA(PWDATA), .PRDATA(PRDATA),
        .PREADY(PREADY), .SPIOut(SPIOut), .SPIIn(SPIIn), .Sck(Sck),
        .SPICS(SPICS), .SPIIntr(SPIIntr)
    );

    assign SPIIn = SPIOut;

    initial begin
        PCLK = 1'b0;
        forever #5 PCLK = ~PCLK;
    end

    //////////////////////////////////////////////////////////////////////
    // Failure reporting and bus tasks
    //////////////////////////////////////////////////////////////////////

    task automatic abortRun(input string line);
        $display("%s", line);
        $display("Some tests failed");
        $fatal(1, "Run stopped at first error");
    endtask

    task automatic mismatch(input string msg);
        abortRun($sformatf("Mismatch at %0t ns: %s", $time, msg));
    endtask

    task automatic checkEq(input string what, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp)
            else mismatch($sformatf("%s is 0x%0h, expected 0x%0h", what, got, exp));
    endtask

    task automatic apbWrite(input logic [7:0] addr, input logic [31:0] data);
        @(negedge PCLK);
        PSEL    = 1'b1;
        PENABLE = 1'b0;
        PWRITE  = 1'b1;
        PADDR   = addr;
        PWDATA  = data;
        @(negedge PCLK);
        PENABLE = 1'b1;
        @(negedge PCLK);
        PSEL    = 1'b0;
        PENABLE = 1'b0;
        PWRITE  = 1'b0;
    endtask

    // PRDATA is sampled in the access phase
    task automatic apbRead(input logic [7:0] addr, output logic [31:0] data);
        @(negedge PCLK);
        PSEL    = 1'b1;
        PENABLE = 1'b0;
        PWRITE  = 1'b0;
        PADDR   = addr;
        @(negedge PCLK);
        PENABLE = 1'b1;
        data    = PRDATA;
        @(negedge PCLK);
        PSEL    = 1'b0;
        PENABLE = 1'b0;
    endtask

    task automatic expectRead(input logic [7:0] addr, input logic [31:0] exp,
                              input string what);
        logic [31:0] word;
        apbRead(addr, word);
        checkEq(what, word, exp);
    endtask

    task automatic setCfg(input int div, input logic [1:0] mode, input logic [1:0] id,
                          input logic [3:0] def, input logic [1:0] csm);
        monOn = 1'b0;
        apbWrite(SCKDIV, 32'(div));
        apbWrite(SCKMODE, {30'h0, mode});
        apbWrite(CSID, {30'h0, id});
        apbWrite(CSDEF, {28'h0, def});
        apbWrite(CSMODE, {30'h0, csm});
        csDefCur  = def;
        csIdCur   = id;
        csModeCur = csm;
        polCur    = mode[1];
        @(negedge PCLK);
        monOn = 1'b1;
    endtask

    // Engine is idle once chip select stays released longer than one tick period
    task automatic waitCsRelease(input int quietNeed);
        int quiet;
        int cycles;
        quiet  = 0;
        cycles = 0;
        while (quiet < quietNeed) begin
            @(negedge PCLK);
            cycles++;
            if (SPICS == csDefCur) quiet++;
            else quiet = 0;
            if (cycles > 50000) abortRun("Timeout: chip select was never released");
        end
    endtask

    task automatic popRx(output logic [7:0] data);
        logic [31:0] word;
        int tries;
        tries = 0;
        word  = 32'h100;
        while (word[8]) begin
            if (tries == 500) abortRun("Timeout: receive FIFO stayed empty");
            else begin
                apbRead(RXDATA, word);
                tries++;
            end
        end
        data = word[7:0];
    endtask

    task automatic pollIp(input int bitIdx, input logic want, input string what);
        logic [31:0] word;
        int tries;
        tries = 0;
        apbRead(IP, word);
        while (word[bitIdx] !== want) begin
            tries++;
            if (tries > 200) abortRun({"Timeout: ", what});
            else apbRead(IP, word);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Monitors
    //////////////////////////////////////////////////////////////////////

    // Samples taken before the edge like the DUT's own flops
    always @(posedge PCLK) begin : occupancyModel
        logic       act;
        logic [3:0] tx;
        logic [3:0] rx;
        act = (SPICS != csDefCur);
        // Rising chip select marks a TX pop, falling a RX push one edge back
        tx = txCnt + {3'b0, txPushEv} - {3'b0, act && !prevAct};
        rx = rxCnt - {3'b0, rxPopEv} + {3'b0, !act && prevAct && rxCnt < 4'd8};
        prevAct <= act;
        if (!intrOn) begin
            txCnt      <= 4'd0;
            rxCnt      <= 4'd0;
            txPushEv   <= 1'b0;
            rxPopEv    <= 1'b0;
            modelReady <= 1'b0;
        end else begin
            txCnt      <= tx;
            rxCnt      <= rx;
            txPushEv   <= PSEL && PENABLE && PWRITE && PADDR == TXDATA && tx < 4'd8;
            // The returned word was loaded one edge back, when the count was rxCnt
            rxPopEv    <= PSEL && PENABLE && !PWRITE && PADDR == RXDATA && rxCnt != 4'd0;
            expIntr    <= (tx < 4'd2) || (rx > 4'd1);
            modelReady <= 1'b1;
        end
    end

    always @(negedge PCLK) begin
        if (monOn) begin
            assert (((SPICS ^ csDefCur) & ~(4'b1 << csIdCur)) == 4'b0)
                else mismatch("SPICS changed a pin other than the selected one");
            if (SPICS == csDefCur && csModeCur != OFF) begin
                assert (Sck == polCur) else mismatch("Sck left its idle level between frames");
            end
        end
        if (modelReady) begin
            assert (SPIIntr == expIntr) else mismatch("SPIIntr disagrees with FIFO occupancy");
        end
    end

    csOffHeld: assert property (@(posedge PCLK) (monOn && csModeCur == OFF) |-> (SPICS == csDefCur))
        else mismatch("SPICS left its default level in off mode");

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////

    initial begin
        logic [31:0] word;
        logic [7:0]  got;
        logic [7:0]  sent [10];
        int          n;

        seed       = 32'h486c;
        PRESETn    = 1'b0;
        PSEL       = 1'b0;
        PENABLE    = 1'b0;
        PWRITE     = 1'b0;
        PADDR      = 8'h00;
        PWDATA     = 32'h0;
        csDefCur   = 4'hF;
        csIdCur    = 2'd0;
        csModeCur  = 2'd0;
        polCur     = 1'b0;
        monOn      = 1'b0;
        intrOn     = 1'b0;
        modelReady = 1'b0;
        repeat (2) @(posedge PCLK);
        @(negedge PCLK);
        PRESETn = 1'b1;

        // Reset values
        checkEq("SPICS after reset", {28'h0, SPICS}, 32'hF);
        checkEq("Sck/SPIOut/SPIIntr/PREADY", {28'h0, Sck, SPIOut, SPIIntr, PREADY}, 32'h1);
        expectRead(SCKDIV, 32'h3, "SCKDIV");
        expectRead(SCKMODE, 32'h0, "SCKMODE");
        expectRead(CSID, 32'h0, "CSID");
        expectRead(CSDEF, 32'hF, "CSDEF");
        expectRead(CSMODE, 32'h0, "CSMODE");
        expectRead(TXDATA, 32'h0, "TXDATA");
        expectRead(RXDATA, 32'h100, "RXDATA");
        expectRead(TXMARK, 32'h0, "TXMARK");
        expectRead(RXMARK, 32'h0, "RXMARK");
        expectRead(IE, 32'h0, "IE");
        expectRead(IP, 32'h0, "IP");
        monOn = 1'b1;

        // Loopback in all four clock modes
        for (int m = 0; m < 4; m++) begin
            setCfg($random(seed) & 32'h3, m[1:0], 2'($random(seed)), 4'($random(seed)), AUTO);
            for (int i = 0; i < 3; i++) begin
                sent[i] = 8'($random(seed));
                apbWrite(TXDATA, {24'h0, sent[i]});
            end
            for (int i = 0; i < 3; i++) begin
                popRx(got);
                checkEq("loopback byte", {24'h0, got}, {24'h0, sent[i]});
            end
            waitCsRelease(8);
        end

        // Chip select off with polarity high
        setCfg(1, 2'b10, 2'($random(seed)), 4'hF, OFF);
        for (int i = 0; i < 2; i++) begin
            sent[i] = 8'($random(seed));
            apbWrite(TXDATA, {24'h0, sent[i]});
        end
        for (int i = 0; i < 2; i++) begin
            popRx(got);
            checkEq("byte with chip select off", {24'h0, got}, {24'h0, sent[i]});
        end
        repeat (10) begin
            @(negedge PCLK);
            assert (Sck == polCur) else mismatch("Sck not at polarity after the last frame");
        end

        // Ten bytes sent while only eight fit in the RX FIFO
        setCfg(0, 2'($random(seed)), 2'($random(seed)), 4'hF, AUTO);
        for (int i = 0; i < 10; i++) begin
            sent[i] = 8'($random(seed));
            apbWrite(TXDATA, {24'h0, sent[i]});
            if (i == 4 || i == 9) waitCsRelease(3);
        end
        for (int i = 0; i < 8; i++) begin
            popRx(got);
            checkEq("buffered byte", {24'h0, got}, {24'h0, sent[i]});
        end
        apbRead(RXDATA, word);
        checkEq("RXDATA empty flag", {31'h0, word[8]}, 32'h1);

        // TX full flag with the slowest serial clock
        setCfg(4095, 2'b00, 2'd0, 4'hF, AUTO);
        n    = 0;
        word = 32'h0;
        while (!word[8]) begin
            assert (n < 10) else mismatch("TXDATA full flag not set within ten writes");
            apbWrite(TXDATA, {24'h0, 8'($random(seed))});
            apbRead(TXDATA, word);
            n++;
        end
        apbWrite(SCKDIV, 32'h0);
        waitCsRelease(3);
        n    = 0;
        word = 32'h0;
        while (!word[8]) begin
            if (n == 12) abortRun("Timeout: receive FIFO never drained");
            else begin
                apbRead(RXDATA, word);
                n++;
            end
        end

        // Watermark interrupts
        setCfg(0, 2'b00, 2'($random(seed)), 4'hF, AUTO);
        apbWrite(TXMARK, 32'd2);
        apbWrite(RXMARK, 32'd1);
        apbWrite(IE, 32'd3);
        intrOn = 1'b1;
        expectRead(IP, 32'h1, "IP with both FIFOs empty");
        for (int i = 0; i < 6; i++) begin
            sent[i] = 8'($random(seed));
            apbWrite(TXDATA, {24'h0, sent[i]});
        end
        pollIp(0, 1'b0, "TX pending never cleared");
        pollIp(1, 1'b1, "RX pending never set");
        pollIp(0, 1'b1, "TX pending never set after draining");
        for (int i = 0; i < 6; i++) begin
            popRx(got);
            checkEq("byte under interrupt test", {24'h0, got}, {24'h0, sent[i]});
        end
        pollIp(1, 1'b0, "RX pending never cleared");

        $display("All tests passed");
        $finish;
    end

endmodule

/* list.f */
src/spiRegPkg.sv
src/spiXferPkg.sv
src/spiApbRegs.sv
src/spiFifo.sv
src/spiClockGen.sv
src/spiXferEngine.sv
src/spiApb.sv
verif/spiApbTb.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = spiApbTb
FILELIST = list.f
OBJDIR   = obj_dir
PASS_MSG = All tests passed

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
